// File: include/decoder_defs.svh
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// datapath word width
`define DATA_W 32

// register number width, r0 to r15
`define REG_SEL_W 4

// decoded records buffered between the classifier and the control generator
`define FIFO_DEPTH 4

// fixed register numbers
`define PC_REG 4'd15
`define LR_REG 4'd14

// MOV r0, r0 with condition AL
// cond 1110, 00 I=0, opcode 1101, S=0, Rn 0, Rd 0, shift amount 0, LSL, Rm 0
`define NOP_INSTR 32'hE1A0_0000

`endif

// File: src/decoder_pkg.sv
`include "decoder_defs.svh"

package decoder_pkg;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
    } cond_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef enum logic [2:0] {
        DP_IMM_SHIFT,
        DP_REG_SHIFT,
        DP_IMM,
        BRANCH,
        UNSUPPORTED
    } instr_kind_t;

    typedef enum logic [3:0] {
        ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB, ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
        ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN, ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
    } alu_op_t;

    // the low two bits match the shift type field of the instruction
    typedef enum logic [2:0] {
        BARREL_LSL = 3'b000,
        BARREL_LSR = 3'b001,
        BARREL_ASR = 3'b010,
        BARREL_ROR = 3'b011,
        BARREL_RRX = 3'b100
    } barrel_op_t;

    typedef struct packed {
        instr_kind_t           kind;
        alu_op_t               opcode;
        logic                  s_bit;
        logic [`REG_SEL_W-1:0] rn;
        logic [`REG_SEL_W-1:0] rd;
        logic [`REG_SEL_W-1:0] rm;
        logic [`REG_SEL_W-1:0] rs;
        logic [4:0]            shamt;
        logic [1:0]            shift_type;
        logic [3:0]            rotate;
        logic [7:0]            imm8;
        logic [23:0]           offset;      // signed word offset of a branch
        logic                  link;
    } decoded_instr_t;

    typedef struct packed {
        logic [`REG_SEL_W-1:0] read_a_sel;
        logic [`REG_SEL_W-1:0] read_b_sel;
        logic [`REG_SEL_W-1:0] read_c_sel;
        logic [`REG_SEL_W-1:0] write_sel;
        barrel_op_t            barrel_op;
        alu_op_t               alu_op;
        logic [`DATA_W-1:0]    shift_val;
        logic [`DATA_W-1:0]    immediate;
        logic                  read_b_en;
        logic                  imm_en;
        logic                  reg_write_en;
        logic                  pc_write_en;
        logic                  lr_write_en;
        logic                  cpsr_write_en;
        logic                  shift_by_reg;
    } ctrl_word_t;

endpackage

// File: src/cond_eval.sv
`timescale 1ns/10ps

module cond_eval (
    input  logic [3:0] cond,
    input  logic [3:0] flags,        // n z c v
    output logic       execute_en
);

    logic n;
    logic z;
    logic c;
    logic v;

    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    always_comb
    begin
        case (cond)
            4'h0:    execute_en = z;                 // EQ
            4'h1:    execute_en = !z;                // NE
            4'h2:    execute_en = c;                 // CS / HS
            4'h3:    execute_en = !c;                // CC / LO
            4'h4:    execute_en = n;                 // MI
            4'h5:    execute_en = !n;                // PL
            4'h6:    execute_en = v;                 // VS
            4'h7:    execute_en = !v;                // VC
            4'h8:    execute_en = c && !z;           // HI unsigned higher
            4'h9:    execute_en = !c || z;           // LS
            4'hA:    execute_en = (n == v);          // GE
            4'hB:    execute_en = (n != v);          // LT
            4'hC:    execute_en = !z && (n == v);    // GT
            4'hD:    execute_en = z || (n != v);     // LE
            4'hE:    execute_en = 1'b1;              // AL
            default: execute_en = 1'b0;              // NV is never taken
        endcase
    end

endmodule

// File: src/instr_classifier.sv
`timescale 1ns/10ps
`include "decoder_defs.svh"

module instr_classifier (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    output logic                        instr_ready,
    input  logic [`DATA_W-1:0]          instr,
    input  decoder_pkg::flags_t         flags,
    output logic                        rec_valid,
    input  logic                        rec_ready,
    output decoder_pkg::decoded_instr_t rec
);

    logic                        live;          // low in the first cycle out of reset
    logic                        execute_en;
    decoder_pkg::cond_t          cond;
    logic [`DATA_W-1:0]          cond_instr;
    logic [3:0]                  class_bits;
    decoder_pkg::decoded_instr_t next_rec;

    assign cond = decoder_pkg::cond_t'(instr[31:28]);

    cond_eval cond_eval_inst (
        .cond       (cond),
        .flags      (flags),
        .execute_en (execute_en)
    );

    // a failed condition turns the word into a no-op
    assign cond_instr = execute_en ? instr : `NOP_INSTR;
    assign class_bits = {cond_instr[27:25], cond_instr[4]};   // ARM encoding class

    always_comb
    begin
        case (class_bits)
            4'b0000:          next_rec.kind = decoder_pkg::DP_IMM_SHIFT;
            4'b0001:          next_rec.kind = decoder_pkg::DP_REG_SHIFT;
            4'b0010, 4'b0011: next_rec.kind = decoder_pkg::DP_IMM;
            4'b1010, 4'b1011: next_rec.kind = decoder_pkg::BRANCH;
            default:          next_rec.kind = decoder_pkg::UNSUPPORTED;  // loads, stores, rest
        endcase
        next_rec.opcode     = decoder_pkg::alu_op_t'(cond_instr[24:21]);
        next_rec.s_bit      = cond_instr[20];
        next_rec.rn         = cond_instr[19:16];
        next_rec.rd         = cond_instr[15:12];
        next_rec.rm         = cond_instr[3:0];
        next_rec.rs         = cond_instr[11:8];
        next_rec.shamt      = cond_instr[11:7];
        next_rec.shift_type = cond_instr[6:5];
        next_rec.rotate     = cond_instr[11:8];
        next_rec.imm8       = cond_instr[7:0];
        next_rec.offset     = cond_instr[23:0];
        next_rec.link       = cond_instr[24];    // L bit of BL
    end

    // take a new word when empty or when the held record leaves this cycle
    assign instr_ready = live && (!rec_valid || rec_ready);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            live      <= 1'b0;
            rec_valid <= 1'b0;
        end
        else
        begin
            live <= 1'b1;
            if (instr_valid && instr_ready)
                rec_valid <= 1'b1;
            else if (rec_ready)
                rec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid && instr_ready)
            rec <= next_rec;
    end

    // a stalled record must hold until the FIFO takes it
    a_rec_stable: assert property (@(posedge clk) disable iff (rst)
        rec_valid && !rec_ready |=> rec_valid && $stable(rec));

endmodule

// File: src/decode_fifo.sv
`timescale 1ns/10ps

module decode_fifo #(
    parameter type payload_t = decoder_pkg::decoded_instr_t,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;    // seen at the head one cycle later at the earliest
    end

    // overflow would push count past DEPTH
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        count == CNT_W'(DEPTH) && !pop |=> count == CNT_W'(DEPTH));

    // underflow would wrap count below zero
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        count == '0 && !push |=> count == '0);

endmodule

// File: src/control_gen.sv
`timescale 1ns/10ps
`include "decoder_defs.svh"

module control_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rec_valid,
    output logic                        rec_ready,
    input  decoder_pkg::decoded_instr_t rec,
    output logic                        ctrl_valid,
    input  logic                        ctrl_ready,
    output decoder_pkg::ctrl_word_t     ctrl
);

    decoder_pkg::ctrl_word_t next_ctrl;
    logic                    is_dp;
    logic                    test_op;
    logic [`DATA_W-1:0]      branch_off;

    assign is_dp = rec.kind inside {decoder_pkg::DP_IMM_SHIFT, decoder_pkg::DP_REG_SHIFT,
                                    decoder_pkg::DP_IMM};

    // compare and test ops only touch the flags
    assign test_op = rec.opcode inside {decoder_pkg::ALU_TST, decoder_pkg::ALU_TEQ,
                                        decoder_pkg::ALU_CMP, decoder_pkg::ALU_CMN};

    // word offset to bytes, sign extended
    assign branch_off = {{(`DATA_W - 26){rec.offset[23]}}, rec.offset, 2'b00};

    always_comb
    begin
        next_ctrl = '0;    // unsupported words keep every enable low
        if (is_dp)
        begin
            next_ctrl.read_a_sel    = rec.rn;
            next_ctrl.write_sel     = rec.rd;
            next_ctrl.alu_op        = rec.opcode;
            next_ctrl.cpsr_write_en = rec.s_bit;
            next_ctrl.reg_write_en  = !test_op;
            next_ctrl.pc_write_en   = (rec.rd == `PC_REG);
        end
        case (rec.kind)
            decoder_pkg::DP_IMM_SHIFT:
            begin
                next_ctrl.read_b_sel = rec.rm;
                next_ctrl.read_b_en  = 1'b1;
                next_ctrl.barrel_op  = (rec.shamt == 5'd0) ? decoder_pkg::BARREL_RRX :
                                       decoder_pkg::barrel_op_t'({1'b0, rec.shift_type});
                next_ctrl.shift_val  = {{(`DATA_W - 5){1'b0}}, rec.shamt};
            end
            decoder_pkg::DP_REG_SHIFT:
            begin
                next_ctrl.read_b_sel   = rec.rm;
                next_ctrl.read_b_en    = 1'b1;
                next_ctrl.read_c_sel   = rec.rs;    // shift amount from Rs
                next_ctrl.shift_by_reg = 1'b1;
                next_ctrl.barrel_op    = decoder_pkg::barrel_op_t'({1'b0, rec.shift_type});
            end
            decoder_pkg::DP_IMM:
            begin
                next_ctrl.imm_en    = 1'b1;
                next_ctrl.immediate = {{(`DATA_W - 8){1'b0}}, rec.imm8};
                next_ctrl.barrel_op = decoder_pkg::BARREL_LSL;
                next_ctrl.shift_val = {{(`DATA_W - 5){1'b0}}, rec.rotate, 1'b0};  // rotate * 2
            end
            decoder_pkg::BRANCH:
            begin
                // PC + offset, the extra 4 since PC already points at the next word
                next_ctrl.read_a_sel   = `PC_REG;
                next_ctrl.write_sel    = `PC_REG;
                next_ctrl.alu_op       = decoder_pkg::ALU_ADD;
                next_ctrl.imm_en       = 1'b1;
                next_ctrl.immediate    = branch_off + `DATA_W'(4);
                next_ctrl.reg_write_en = 1'b1;
                next_ctrl.pc_write_en  = 1'b1;
                next_ctrl.lr_write_en  = rec.link;
            end
            default:
            begin
                next_ctrl.barrel_op = decoder_pkg::BARREL_LSL;
            end
        endcase
    end

    assign rec_ready = !ctrl_valid || ctrl_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            ctrl_valid <= 1'b0;
        else if (rec_valid && rec_ready)
            ctrl_valid <= 1'b1;
        else if (ctrl_ready)
            ctrl_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rec_valid && rec_ready)
            ctrl <= next_ctrl;
    end

    // a PC write is only ever aimed at r15
    a_pc_write_sel: assert property (@(posedge clk) disable iff (rst)
        ctrl_valid && ctrl.pc_write_en |-> ctrl.write_sel == `PC_REG);

endmodule

// File: src/decode_top.sv
`timescale 1ns/10ps
`include "decoder_defs.svh"

module decode_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    input  logic [`DATA_W-1:0]    instr,
    input  logic [3:0]            flags,          // n z c v
    output logic                  ctrl_valid,
    input  logic                  ctrl_ready,
    output logic [`REG_SEL_W-1:0] read_a_sel,
    output logic [`REG_SEL_W-1:0] read_b_sel,
    output logic [`REG_SEL_W-1:0] read_c_sel,
    output logic [`REG_SEL_W-1:0] write_sel,
    output logic [2:0]            barrel_op,
    output logic [3:0]            alu_op,
    output logic [`DATA_W-1:0]    shift_val,
    output logic [`DATA_W-1:0]    immediate,
    output logic                  read_b_en,
    output logic                  imm_en,
    output logic                  reg_write_en,
    output logic                  pc_write_en,
    output logic                  lr_write_en,
    output logic                  cpsr_write_en,
    output logic                  shift_by_reg
);

    logic                        rec_valid;
    logic                        rec_ready;
    decoder_pkg::decoded_instr_t rec;
    logic                        q_valid;
    logic                        q_ready;
    decoder_pkg::decoded_instr_t q;
    decoder_pkg::ctrl_word_t     ctrl;

    instr_classifier instr_classifier_inst (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr(instr), .flags(flags),
        .rec_valid(rec_valid), .rec_ready(rec_ready), .rec(rec)
    );

    decode_fifo #(
        .payload_t (decoder_pkg::decoded_instr_t),
        .DEPTH     (`FIFO_DEPTH)
    ) decode_fifo_inst (
        .clk(clk), .rst(rst),
        .in_valid(rec_valid), .in_ready(rec_ready), .in_data(rec),
        .out_valid(q_valid), .out_ready(q_ready), .out_data(q)
    );

    control_gen control_gen_inst (
        .clk(clk), .rst(rst),
        .rec_valid(q_valid), .rec_ready(q_ready), .rec(q),
        .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready), .ctrl(ctrl)
    );

    // control word out as separate datapath ports
    assign read_a_sel    = ctrl.read_a_sel;
    assign read_b_sel    = ctrl.read_b_sel;
    assign read_c_sel    = ctrl.read_c_sel;
    assign write_sel     = ctrl.write_sel;
    assign barrel_op     = ctrl.barrel_op;
    assign alu_op        = ctrl.alu_op;
    assign shift_val     = ctrl.shift_val;
    assign immediate     = ctrl.immediate;
    assign read_b_en     = ctrl.read_b_en;
    assign imm_en        = ctrl.imm_en;
    assign reg_write_en  = ctrl.reg_write_en;
    assign pc_write_en   = ctrl.pc_write_en;
    assign lr_write_en   = ctrl.lr_write_en;
    assign cpsr_write_en = ctrl.cpsr_write_en;
    assign shift_by_reg  = ctrl.shift_by_reg;

endmodule

// File: bench/tb_decode.sv
`timescale 1ns/10ps
`include "decoder_defs.svh"

module tb_decode;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic                  instr_ready;
    logic [`DATA_W-1:0]    instr;
    logic [3:0]            flags;
    logic                  ctrl_valid;
    logic                  ctrl_ready;
    logic [`REG_SEL_W-1:0] read_a_sel;
    logic [`REG_SEL_W-1:0] read_b_sel;
    logic [`REG_SEL_W-1:0] read_c_sel;
    logic [`REG_SEL_W-1:0] write_sel;
    logic [2:0]            barrel_op;
    logic [3:0]            alu_op;
    logic [`DATA_W-1:0]    shift_val;
    logic [`DATA_W-1:0]    immediate;
    logic                  read_b_en;
    logic                  imm_en;
    logic                  reg_write_en;
    logic                  pc_write_en;
    logic                  lr_write_en;
    logic                  cpsr_write_en;
    logic                  shift_by_reg;

    decoder_pkg::ctrl_word_t seen;                  // control word as it leaves the DUT
    decoder_pkg::ctrl_word_t exp_head;              // oldest word still owed
    decoder_pkg::ctrl_word_t exp_q[$];
    logic [`DATA_W-1:0]      stim_word[$];
    logic [3:0]              stim_flags[$];
    logic [`DATA_W-1:0]      rand_word;
    int                      pending = 0;
    int                      sent = 0;
    int                      received = 0;
    int                      errors = 0;
    int                      cycles = 0;
    int                      limit = 0;

    decode_top UUT (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr), .flags(flags),
        .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready),
        .read_a_sel(read_a_sel), .read_b_sel(read_b_sel), .read_c_sel(read_c_sel),
        .write_sel(write_sel), .barrel_op(barrel_op), .alu_op(alu_op),
        .shift_val(shift_val), .immediate(immediate),
        .read_b_en(read_b_en), .imm_en(imm_en), .reg_write_en(reg_write_en),
        .pc_write_en(pc_write_en), .lr_write_en(lr_write_en),
        .cpsr_write_en(cpsr_write_en), .shift_by_reg(shift_by_reg)
    );

    assign seen = {read_a_sel, read_b_sel, read_c_sel, write_sel, barrel_op, alu_op,
                   shift_val, immediate, read_b_en, imm_en, reg_write_en, pc_write_en,
                   lr_write_en, cpsr_write_en, shift_by_reg};

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // even codes test a flag term and odd codes invert it
    function automatic logic cond_passes(input logic [3:0] cond, input logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        logic base;
        n = nzcv[3];
        z = nzcv[2];
        c = nzcv[1];
        v = nzcv[0];
        case (cond[3:1])
            3'd0:    base = z;
            3'd1:    base = c;
            3'd2:    base = n;
            3'd3:    base = v;
            3'd4:    base = c && !z;
            3'd5:    base = (n == v);
            3'd6:    base = !z && (n == v);
            default: base = 1'b1;
        endcase
        return cond[0] ? !base : base;
    endfunction

    function automatic decoder_pkg::barrel_op_t shift_type_op(input logic [1:0] st);
        case (st)
            2'b00:   return decoder_pkg::BARREL_LSL;
            2'b01:   return decoder_pkg::BARREL_LSR;
            2'b10:   return decoder_pkg::BARREL_ASR;
            default: return decoder_pkg::BARREL_ROR;
        endcase
    endfunction

    function automatic decoder_pkg::ctrl_word_t expected_ctrl(input logic [31:0] word_in,
                                                              input logic [3:0] nzcv);
        decoder_pkg::ctrl_word_t e;
        logic [31:0]             w;
        logic [3:0]              op;
        w = cond_passes(word_in[31:28], nzcv) ? word_in : `NOP_INSTR;
        op = w[24:21];
        e = '0;
        if (w[27:26] == 2'b00)
        begin
            e.read_a_sel    = w[19:16];
            e.write_sel     = w[15:12];
            e.alu_op        = decoder_pkg::alu_op_t'(op);
            e.cpsr_write_en = w[20];
            e.reg_write_en  = (op[3:2] != 2'b10);    // TST TEQ CMP CMN
            e.pc_write_en   = (w[15:12] == 4'd15);
            if (w[25])
            begin
                e.imm_en    = 1'b1;
                e.immediate = 32'(w[7:0]);
                e.shift_val = 32'(w[11:8]) << 1;
                e.barrel_op = decoder_pkg::BARREL_LSL;
            end
            else if (w[4])
            begin
                e.read_b_sel   = w[3:0];
                e.read_b_en    = 1'b1;
                e.read_c_sel   = w[11:8];
                e.shift_by_reg = 1'b1;
                e.barrel_op    = shift_type_op(w[6:5]);
            end
            else
            begin
                e.read_b_sel = w[3:0];
                e.read_b_en  = 1'b1;
                e.shift_val  = 32'(w[11:7]);
                e.barrel_op  = (w[11:7] == 5'd0) ? decoder_pkg::BARREL_RRX
                                                 : shift_type_op(w[6:5]);
            end
        end
        else if (w[27:25] == 3'b101)
        begin
            e.read_a_sel   = 4'd15;
            e.write_sel    = 4'd15;
            e.alu_op       = decoder_pkg::ALU_ADD;
            e.imm_en       = 1'b1;                  // offset rides the immediate path
            e.immediate    = 32'($signed(w[23:0])) * 4 + 4;
            e.reg_write_en = 1'b1;
            e.pc_write_en  = 1'b1;
            e.lr_write_en  = w[24];
        end
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic report_mismatch(input decoder_pkg::ctrl_word_t e,
                                   input decoder_pkg::ctrl_word_t a);
        compare_field("read_a_sel", 32'(e.read_a_sel), 32'(a.read_a_sel));
        compare_field("read_b_sel", 32'(e.read_b_sel), 32'(a.read_b_sel));
        compare_field("read_c_sel", 32'(e.read_c_sel), 32'(a.read_c_sel));
        compare_field("write_sel", 32'(e.write_sel), 32'(a.write_sel));
        compare_field("barrel_op", 32'(e.barrel_op), 32'(a.barrel_op));
        compare_field("alu_op", 32'(e.alu_op), 32'(a.alu_op));
        compare_field("shift_val", e.shift_val, a.shift_val);
        compare_field("immediate", e.immediate, a.immediate);
        compare_field("read_b_en", 32'(e.read_b_en), 32'(a.read_b_en));
        compare_field("imm_en", 32'(e.imm_en), 32'(a.imm_en));
        compare_field("reg_write_en", 32'(e.reg_write_en), 32'(a.reg_write_en));
        compare_field("pc_write_en", 32'(e.pc_write_en), 32'(a.pc_write_en));
        compare_field("lr_write_en", 32'(e.lr_write_en), 32'(a.lr_write_en));
        compare_field("cpsr_write_en", 32'(e.cpsr_write_en), 32'(a.cpsr_write_en));
        compare_field("shift_by_reg", 32'(e.shift_by_reg), 32'(a.shift_by_reg));
    endtask

    task automatic add_stim(input logic [31:0] w, input logic [3:0] f);
        stim_word.push_back(w);
        stim_flags.push_back(f);
    endtask

    // reference queue with its head published for the assertions
    always @(posedge clk)
    begin
        if (rst)
            exp_q.delete();
        else
        begin
            if (ctrl_valid && ctrl_ready && exp_q.size() > 0)
                void'(exp_q.pop_front());
            if (ctrl_valid && ctrl_ready)
                received++;
            if (instr_valid && instr_ready)
            begin
                exp_q.push_back(expected_ctrl(instr, flags));
                sent++;
            end
        end
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
        pending  <= exp_q.size();
    end

    a_ctrl_match: assert property (@(posedge clk) disable iff (rst)
        ctrl_valid && ctrl_ready && pending != 0 |-> seen == exp_head)
        else report_mismatch($sampled(exp_head), $sampled(seen));

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        ctrl_valid && ctrl_ready |-> pending != 0)
        else
        begin
            errors++;
            $display("control word came out with no instruction waiting at %0t", $time);
        end

    always @(posedge clk)
    begin
        if (!rst)
            cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit)
        begin
            $display("timeout after %0d cycles, %0d of %0d words came out",
                     cycles, received, sent);
            $display("errors: %0d", errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(39693));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        flags       = 4'h0;
        ctrl_ready  = 1'b0;
        add_stim(32'h00821203, 4'b0000);    // EQ with Z clear becomes a nop
        add_stim(32'h00821203, 4'b0100);
        add_stim(32'hF0821203, 4'b1111);    // NV
        add_stim(32'hC0821203, 4'b1000);    // GT fails as N != V
        add_stim(32'hE0821203, 4'h0);       // ADD r1, r2, r3, LSL #4
        add_stim(32'hE1A01063, 4'h0);       // RRX
        add_stim(32'hE1520003, 4'h0);       // CMP
        add_stim(32'hE1320003, 4'h0);       // TEQ
        add_stim(32'hE08FF002, 4'h0);       // Rd = pc
        add_stim(32'hE0821413, 4'h0);       // register shift by r4
        add_stim(32'hE3A053AB, 4'h0);       // MOV r5, #0xAB ror 6
        add_stim(32'hE3A0F4FF, 4'h0);
        add_stim(32'hEAFFFFFE, 4'h0);       // backward branch
        add_stim(32'hEB000010, 4'h0);       // BL
        add_stim(32'hE5912004, 4'h0);       // LDR
        add_stim(32'hE5812004, 4'h0);       // STR
        add_stim(32'hE7912003, 4'h0);       // register offset load
        add_stim(32'hE8BD8000, 4'h0);       // LDM is outside the kept classes
        repeat (200)
        begin
            rand_word = $urandom();
            if ($urandom_range(1, 0) == 1)
                rand_word[31:28] = 4'hE;
            add_stim(rand_word, 4'($urandom()));
        end
        limit = 20 * stim_word.size() + 50;
        fork
            forever
            begin
                @(posedge clk);
                ctrl_ready <= ($urandom_range(99, 0) >= 40);    // about 40% stall
            end
        join_none
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (stim_word[i])
        begin
            if ($urandom_range(3, 0) == 0)
            begin
                instr_valid <= 1'b0;
                @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr       <= stim_word[i];
            flags       <= stim_flags[i];
            @(posedge clk);
            while (!instr_ready)
                @(posedge clk);
        end
        instr_valid <= 1'b0;
        wait (received == stim_word.size());
        repeat (4) @(posedge clk);
        $display("errors: %0d, sent: %0d, received: %0d", errors, sent, received);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
src/decoder_pkg.sv
src/cond_eval.sv
src/instr_classifier.sv
src/decode_fifo.sv
src/control_gen.sv
src/decode_top.sv
bench/tb_decode.sv
